// ==== i2f.f ====
common/i2f_pkg.sv
src/lzc.sv
conv/i2f_norm.sv
conv/i2f_round.sv
src/i2f_apb_regs.sv
src/i2f_top.sv
test/i2f_props.sv
test/i2f_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the converter testbench with Verilator and run it
# The run passes only if the simulation prints the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module i2f_tb -f i2f.f -o i2f_sim || exit 1
sim_out="$(./obj_dir/i2f_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx 'All tests passed!' && echo "Simulation PASSED" || {
  echo "Simulation FAILED"
  exit 1
}

// ==== test/i2f_tb.sv ====
// Testbench of the APB integer-to-float converter
// Applies a table of hand-derived conversions, random powers of two and bus corner cases
module i2f_tb;

  localparam int unsigned CLK_PERIOD     = 100;
  localparam int unsigned RESET_CYCLES   = 8;
  localparam int unsigned TIMEOUT_CYCLES = 20;
  localparam int unsigned NUM_VEC        = 12;
  localparam int unsigned NUM_RANDOM     = 4;
  // First offset past the register map
  localparam logic [31:0] ADDR_UNMAPPED  = 32'h0000_0010;

  // One table row, the name lives in a separate string array
  typedef struct packed {
    logic [31:0] operand;
    logic        is_unsigned;
    logic [31:0] float_bits;
    logic [4:0]  lz_cnt;
    logic        zero;
  } vector_t;

  logic              clk;
  logic              rst_n;
  i2f_pkg::apb_req_t apb_req;
  i2f_pkg::apb_rsp_t apb_rsp;

  vector_t     vectors [NUM_VEC];
  string       vector_names [NUM_VEC];
  string       cur_test;
  int unsigned test_errs;
  int unsigned tests_run;
  int unsigned tests_failed;
  // Set once a transfer never completes, later transfers are then skipped
  bit          hung;

  i2f_top dut_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic set_vector(input int idx, input string name, input logic [31:0] operand,
                            input logic uns, input logic [31:0] fbits, input logic [4:0] lz,
                            input logic zero);
    vectors[idx]      = '{operand, uns, fbits, lz, zero};
    vector_names[idx] = name;
  endtask

  // Expected words follow the rounding rule by hand, exponent is 158 minus the count
  task automatic load_table();
    set_vector(0, "one", 32'h0000_0001, 1'b0, 32'h3F80_0000, 5'd31, 1'b0);
    set_vector(1, "minus_one", 32'hFFFF_FFFF, 1'b0, 32'hBF80_0000, 5'd31, 1'b0);
    // 100 is 1.5625 times 2**6
    set_vector(2, "hundred", 32'h0000_0064, 1'b0, 32'h42C8_0000, 5'd25, 1'b0);
    set_vector(3, "minus_hundred", 32'hFFFF_FF9C, 1'b0, 32'hC2C8_0000, 5'd25, 1'b0);
    set_vector(4, "most_negative", 32'h8000_0000, 1'b0, 32'hCF00_0000, 5'd0, 1'b0);
    // All 24 kept bits are ones, so rounding carries into the exponent
    set_vector(5, "most_positive", 32'h7FFF_FFFF, 1'b0, 32'h4F00_0000, 5'd1, 1'b0);
    // Exact half below an even LSB stays put
    set_vector(6, "tie_down", 32'h0100_0001, 1'b0, 32'h4B80_0000, 5'd7, 1'b0);
    // Exact half above an odd LSB goes up to the even neighbour
    set_vector(7, "tie_up", 32'h0100_0003, 1'b0, 32'h4B80_0002, 5'd7, 1'b0);
    set_vector(8, "exact", 32'h0100_0002, 1'b0, 32'h4B80_0001, 5'd7, 1'b0);
    // 2**32 - 1 unsigned rounds to 2**32
    set_vector(9, "unsigned_max", 32'hFFFF_FFFF, 1'b1, 32'h4F80_0000, 5'd0, 1'b0);
    set_vector(10, "unsigned_msb", 32'h8000_0000, 1'b1, 32'h4F00_0000, 5'd0, 1'b0);
    set_vector(11, "zero", 32'h0000_0000, 1'b0, 32'h0000_0000, 5'd31, 1'b1);
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("%s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("%s: %0d check(s) failed", cur_test, test_errs);
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s (%s): expected %h, actual %h", cur_test, what, expected, actual);
      test_errs++;
    end
  endtask

  // Looks at the response a quarter period after an edge, once it has settled
  task automatic wait_ready(input string kind, input logic [31:0] addr,
                            output logic [31:0] rdata, output logic err,
                            output int unsigned waits);
    bit done;
    done  = 1'b0;
    waits = 0;
    rdata = '0;
    err   = 1'b0;
    while (!done && waits < TIMEOUT_CYCLES) begin
      #(CLK_PERIOD / 4);
      if (apb_rsp.pready) begin
        done  = 1'b1;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
      end else begin
        waits++;
      end
      // The slave completes or repeats the access on this edge
      @(posedge clk);
    end
    if (!done) begin
      $display("No pready within %0d cycles on %s of address %h", TIMEOUT_CYCLES, kind, addr);
      hung = 1'b1;
      test_errs++;
    end
  endtask

  // The bus is left in its access state, the next transfer or bus_idle moves it on
  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] rdata;
    int unsigned waits;
    err = 1'b1;
    if (!hung) begin
      @(negedge clk);
      apb_req.paddr   = addr;
      apb_req.pwrite  = 1'b1;
      apb_req.pwdata  = data;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      @(negedge clk);
      apb_req.penable = 1'b1;
      wait_ready("write", addr, rdata, err, waits);
    end
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata,
                          output logic err, output int unsigned waits);
    rdata = '0;
    err   = 1'b1;
    waits = 0;
    if (!hung) begin
      @(negedge clk);
      apb_req.paddr   = addr;
      apb_req.pwrite  = 1'b0;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      @(negedge clk);
      apb_req.penable = 1'b1;
      wait_ready("read", addr, rdata, err, waits);
    end
  endtask

  task automatic bus_idle();
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  // Sets the mode, writes the operand and checks RESULT and STATUS
  task automatic run_vector(input int idx);
    logic [31:0] rdata;
    logic        err;
    logic        bus_err;
    int unsigned waits;
    begin_test(vector_names[idx]);
    apb_write(i2f_pkg::ADDR_CTRL, {31'd0, vectors[idx].is_unsigned}, bus_err);
    apb_write(i2f_pkg::ADDR_DATA, vectors[idx].operand, err);
    bus_err |= err;
    apb_read(i2f_pkg::ADDR_RESULT, rdata, err, waits);
    bus_err |= err;
    check_word("result", vectors[idx].float_bits, rdata);
    apb_read(i2f_pkg::ADDR_STATUS, rdata, err, waits);
    bus_err |= err;
    check_word("lz count", {27'd0, vectors[idx].lz_cnt}, {27'd0, rdata[4:0]});
    check_word("zero flag", {31'd0, vectors[idx].zero}, {31'd0, rdata[8]});
    check_word("busy", 32'd0, {31'd0, rdata[9]});
    check_word("pslverr", 32'd0, {31'd0, bus_err});
    end_test();
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] exp_float;
    logic        err;
    int unsigned waits;
    int unsigned k;

    void'($urandom(52));
    apb_req      = '0;
    rst_n        = 1'b0;
    hung         = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    load_table();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Nothing is pending, so RESULT must answer at once
    begin_test("reset_values");
    apb_read(i2f_pkg::ADDR_STATUS, rdata, err, waits);
    check_word("status", 32'd0, rdata);
    apb_read(i2f_pkg::ADDR_RESULT, rdata, err, waits);
    check_word("result", 32'd0, rdata);
    check_word("stall cycles", 32'd0, waits);
    end_test();

    for (int i = 0; i < int'(NUM_VEC); i++) begin
      run_vector(i);
    end

    // 2**k converts exactly, its exponent is 127 + k and its count 31 - k
    begin_test("random_pow2");
    apb_write(i2f_pkg::ADDR_CTRL, 32'd1, err);
    for (int n = 0; n < int'(NUM_RANDOM); n++) begin
      k         = $urandom % 32;
      exp_float = {1'b0, 8'd127 + 8'(k), 23'd0};
      apb_write(i2f_pkg::ADDR_DATA, 32'd1 << k, err);
      apb_read(i2f_pkg::ADDR_RESULT, rdata, err, waits);
      check_word("result", exp_float, rdata);
      apb_read(i2f_pkg::ADDR_STATUS, rdata, err, waits);
      check_word("lz count", {27'd0, 5'(31 - k)}, {27'd0, rdata[4:0]});
    end
    end_test();

    begin_test("result_stall");
    apb_write(i2f_pkg::ADDR_CTRL, 32'd0, err);
    apb_write(i2f_pkg::ADDR_DATA, 32'd3, err);
    apb_read(i2f_pkg::ADDR_RESULT, rdata, err, waits);
    check_word("result", 32'h4040_0000, rdata);
    assert (waits >= 1 && waits <= 2) else begin
      $display("RESULT read right after a DATA write waited %0d cycles, not one or two", waits);
      test_errs++;
    end
    // STATUS right behind the write still sees the job in flight
    apb_write(i2f_pkg::ADDR_DATA, 32'd100, err);
    apb_read(i2f_pkg::ADDR_STATUS, rdata, err, waits);
    check_word("busy", 32'd1, {31'd0, rdata[9]});
    apb_read(i2f_pkg::ADDR_RESULT, rdata, err, waits);
    check_word("result", 32'h42C8_0000, rdata);
    end_test();

    begin_test("unmapped_access");
    apb_write(ADDR_UNMAPPED, 32'hDEAD_BEEF, err);
    check_word("write pslverr", 32'd1, {31'd0, err});
    apb_read(ADDR_UNMAPPED, rdata, err, waits);
    check_word("read pslverr", 32'd1, {31'd0, err});
    check_word("read data", 32'd0, rdata);
    apb_read(i2f_pkg::ADDR_DATA, rdata, err, waits);
    check_word("data", 32'd100, rdata);
    apb_read(i2f_pkg::ADDR_CTRL, rdata, err, waits);
    check_word("ctrl", 32'd0, rdata);
    apb_read(i2f_pkg::ADDR_RESULT, rdata, err, waits);
    check_word("result", 32'h42C8_0000, rdata);
    end_test();

    bus_idle();
    $display("Summary: %0d tests, %0d passed, %0d failed",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== test/i2f_props.sv ====
// Concurrent properties of the converter, bound into its top level
// Covers the APB handshake, the first pipeline step and a trailing zero counter
module i2f_props (
  input logic              clk_i,
  input logic              rst_n_i,
  input i2f_pkg::apb_req_t apb_req_i,
  input i2f_pkg::apb_rsp_t apb_rsp_i,
  input logic              conv_valid_i,
  input logic              norm_valid_i
);

  logic       access;
  // Access cycles spent waiting on pready in the current transfer
  logic [2:0] stall_q;
  // The write data doubles as stimulus for a trailing zero counter
  logic [7:0] probe;
  logic [2:0] probe_cnt;
  logic       probe_empty;

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign probe  = apb_req_i.pwdata[7:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stall_q <= '0;
    end else if (access && !apb_rsp_i.pready) begin
      stall_q <= stall_q + 3'd1;
    end else begin
      stall_q <= '0;
    end
  end

  lzc #(
    .WIDTH (8),
    .MODE  (1'b0)
  ) u_probe_lzc (
    .in_i    (probe),
    .cnt_o   (probe_cnt),
    .empty_o (probe_empty)
  );

  // An access cycle follows a setup cycle or an access that was not ready
  penable_after_setup: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    access |-> $past(apb_req_i.psel && (!apb_req_i.penable || !apb_rsp_i.pready)))
    else $error("access cycle without a preceding setup cycle");

  pready_in_time: assert property (@(posedge clk_i) disable iff (!rst_n_i) stall_q < 3'd3)
    else $error("pready not given within three access cycles");

  norm_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    norm_valid_i == $past(conv_valid_i))
    else $error("norm stage valid does not trail the request by one cycle");

  probe_empty_ok: assert property (@(posedge clk_i) probe_empty == (probe == 8'd0))
    else $error("lzc empty flag disagrees with its input");

  // The count points at a set bit with only zeros below it
  probe_count_ok: assert property (@(posedge clk_i)
    !probe_empty |-> probe[probe_cnt] && ((probe & ((8'd1 << probe_cnt) - 8'd1)) == 8'd0))
    else $error("lzc trailing zero count is wrong");

endmodule

bind i2f_top i2f_props u_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .apb_req_i    (apb_req_i),
  .apb_rsp_i    (apb_rsp_o),
  .conv_valid_i (conv_req.valid),
  .norm_valid_i (norm.valid)
);

// ==== src/i2f_top.sv ====
// Integer-to-float converter behind an APB slave
// Register block feeding the two stage normalise and round pipeline
module i2f_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  i2f_pkg::apb_req_t apb_req_i,
  output i2f_pkg::apb_rsp_t apb_rsp_o
);

  // Job from the register block to the norm stage
  i2f_pkg::conv_req_t            conv_req;
  // Normalised payload between the stages
  i2f_pkg::norm_t                norm;
  // Finished result back to the register block
  logic                          res_valid;
  i2f_pkg::fp32_u                res;
  logic [i2f_pkg::I2F_CNT_W-1:0] lz_cnt;
  logic                          zero;

  i2f_apb_regs u_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .conv_req_o  (conv_req),
    .res_valid_i (res_valid),
    .res_i       (res),
    .lz_cnt_i    (lz_cnt),
    .zero_i      (zero)
  );

  i2f_norm u_norm (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (conv_req),
    .norm_o  (norm)
  );

  i2f_round u_round (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .norm_i      (norm),
    .res_valid_o (res_valid),
    .res_o       (res),
    .lz_cnt_o    (lz_cnt),
    .zero_o      (zero)
  );

endmodule

// ==== src/i2f_apb_regs.sv ====
// APB register block of the converter
// Holds DATA, CTRL and the last result, and stalls RESULT reads while jobs are in flight
module i2f_apb_regs (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  i2f_pkg::apb_req_t             apb_req_i,
  output i2f_pkg::apb_rsp_t             apb_rsp_o,
  output i2f_pkg::conv_req_t            conv_req_o,
  input  logic                          res_valid_i,
  input  i2f_pkg::fp32_u                res_i,
  input  logic [i2f_pkg::I2F_CNT_W-1:0] lz_cnt_i,
  input  logic                          zero_i
);

  // Address decode
  logic                           sel_data;
  logic                           sel_result;
  logic                           sel_status;
  logic                           sel_ctrl;
  logic                           unmapped;

  // Transfer phase
  logic                           access;
  logic                           rd_stall;
  logic                           wr_en;
  logic                           conv_fire;

  // Jobs between the DATA write and the captured result, two at most
  logic [1:0]                     inflight_q;
  logic                           busy;

  // Register file
  logic [i2f_pkg::I2F_DATA_W-1:0] data_q;
  logic                           unsigned_q;
  logic [i2f_pkg::I2F_DATA_W-1:0] result_q;
  logic [i2f_pkg::I2F_CNT_W-1:0]  lz_cnt_q;
  logic                           zero_q;

  logic [i2f_pkg::I2F_DATA_W-1:0] rdata;
  logic [i2f_pkg::I2F_DATA_W-1:0] status;

  always_comb begin
    sel_data   = (apb_req_i.paddr == i2f_pkg::ADDR_DATA);
    sel_result = (apb_req_i.paddr == i2f_pkg::ADDR_RESULT);
    sel_status = (apb_req_i.paddr == i2f_pkg::ADDR_STATUS);
    sel_ctrl   = (apb_req_i.paddr == i2f_pkg::ADDR_CTRL);
    unmapped   = ~(sel_data | sel_result | sel_status | sel_ctrl);
  end

  assign busy   = (inflight_q != 2'd0);
  assign access = apb_req_i.psel & apb_req_i.penable;
  // Only a RESULT read waits, and only while a conversion is pending
  assign rd_stall = access & ~apb_req_i.pwrite & sel_result & busy;
  // Writes always finish in their first access cycle
  assign wr_en     = access & apb_req_i.pwrite;
  assign conv_fire = wr_en & sel_data;

  // The job carries the write data directly, DATA itself updates on the same edge
  always_comb begin
    conv_req_o.valid       = conv_fire;
    conv_req_o.operand     = apb_req_i.pwdata;
    conv_req_o.is_unsigned = unsigned_q;
  end

  always_comb begin
    status = '0;
    status[i2f_pkg::I2F_CNT_W-1:0]      = lz_cnt_q;
    status[i2f_pkg::STATUS_ZERO_BIT]    = zero_q;
    status[i2f_pkg::STATUS_BUSY_BIT]    = busy;
  end

  always_comb begin
    if (sel_data) begin
      rdata = data_q;
    end else if (sel_result) begin
      rdata = result_q;
    end else if (sel_status) begin
      rdata = status;
    end else if (sel_ctrl) begin
      rdata = {{(i2f_pkg::I2F_DATA_W - 1){1'b0}}, unsigned_q};
    end else begin
      rdata = '0;
    end
  end

  // Read data shows only in the completing cycle of a read
  always_comb begin
    apb_rsp_o.pready  = access & ~rd_stall;
    apb_rsp_o.pslverr = access & unmapped;
    if (access & ~rd_stall & ~apb_req_i.pwrite) begin
      apb_rsp_o.prdata = rdata;
    end else begin
      apb_rsp_o.prdata = '0;
    end
  end

  // In-flight counter, a job start and a result can coincide
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      inflight_q <= 2'd0;
    end else if (conv_fire && !res_valid_i) begin
      inflight_q <= inflight_q + 2'd1;
    end else if (!conv_fire && res_valid_i) begin
      inflight_q <= inflight_q - 2'd1;
    end
  end

  // Writes to RESULT and STATUS are dropped, writes outside the map too
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      data_q     <= '0;
      unsigned_q <= 1'b0;
    end else if (wr_en) begin
      if (sel_data) begin
        data_q <= apb_req_i.pwdata;
      end
      if (sel_ctrl) begin
        unsigned_q <= apb_req_i.pwdata[0];
      end
    end
  end

  // Capture each result as it leaves the round stage
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
      lz_cnt_q <= '0;
      zero_q   <= 1'b0;
    end else if (res_valid_i) begin
      result_q <= res_i.bits;
      lz_cnt_q <= lz_cnt_i;
      zero_q   <= zero_i;
    end
  end

endmodule

// ==== conv/i2f_round.sv ====
// Second conversion stage
// Rounds the normalised magnitude to 24 bits and packs the float word
module i2f_round (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  i2f_pkg::norm_t                norm_i,
  output logic                          res_valid_o,
  output i2f_pkg::fp32_u                res_o,
  output logic [i2f_pkg::I2F_CNT_W-1:0] lz_cnt_o,
  output logic                          zero_o
);

  // Bits of the magnitude that fall below the 24 kept bits
  localparam int unsigned DropW = i2f_pkg::I2F_DATA_W - i2f_pkg::FP_MAN_W - 1;

  // Hidden one plus the 23 fraction bits before rounding
  logic [i2f_pkg::FP_MAN_W:0]     kept;
  logic                           lsb;
  logic                           guard;
  logic                           sticky;
  logic                           round_up;
  // One extra bit catches the carry out of the mantissa
  logic [i2f_pkg::FP_MAN_W+1:0]   rounded;
  logic                           carry;
  logic [i2f_pkg::FP_MAN_W-1:0]   frac;
  logic [i2f_pkg::FP_EXP_W-1:0]   exponent;
  i2f_pkg::fp32_u                 res_d;

  // Registered results
  logic                           valid_q;
  i2f_pkg::fp32_u                 res_q;
  logic [i2f_pkg::I2F_CNT_W-1:0]  lz_cnt_q;
  logic                           zero_q;

  always_comb begin
    kept   = norm_i.mant[i2f_pkg::I2F_DATA_W-1:DropW];
    lsb    = norm_i.mant[DropW];
    guard  = norm_i.mant[DropW-1];
    sticky = |norm_i.mant[DropW-2:0];
    // Nearest even: above half rounds up, exactly half rounds up only from an odd LSB
    round_up = guard & (sticky | lsb);
    rounded  = {1'b0, kept} + {{(i2f_pkg::FP_MAN_W + 1){1'b0}}, round_up};
    carry    = rounded[i2f_pkg::FP_MAN_W+1];
    // A carry leaves the mantissa at 10...0 with an all-zero fraction
    frac     = rounded[i2f_pkg::FP_MAN_W-1:0];
    exponent = i2f_pkg::FP_EXP_BASE - {3'b000, norm_i.lz_cnt} + {7'b0000000, carry};

    // A zero input packs as positive zero
    if (norm_i.zero) begin
      res_d.bits = '0;
    end else begin
      res_d.fields.sign     = norm_i.sign;
      res_d.fields.exponent = exponent;
      res_d.fields.mantissa = frac;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= norm_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (norm_i.valid) begin
      res_q    <= res_d;
      lz_cnt_q <= norm_i.lz_cnt;
      zero_q   <= norm_i.zero;
    end
  end

  assign res_valid_o = valid_q;
  assign res_o       = res_q;
  assign lz_cnt_o    = lz_cnt_q;
  assign zero_o      = zero_q;

endmodule

// ==== conv/i2f_norm.sv ====
// First conversion stage
// Forms sign and magnitude, counts leading zeros and normalises the magnitude
module i2f_norm (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  i2f_pkg::conv_req_t req_i,
  output i2f_pkg::norm_t     norm_o
);

  // Sign of the operand, only meaningful in signed mode
  logic                           sign;
  // Absolute value of the operand
  logic [i2f_pkg::I2F_DATA_W-1:0] mag;
  // Number of zeros above the leading one
  logic [i2f_pkg::I2F_CNT_W-1:0]  lz_cnt;
  // High when the magnitude is zero
  logic                           empty;
  // Magnitude shifted so its leading one lands in the MSB
  logic [i2f_pkg::I2F_DATA_W-1:0] mant;

  // Registered stage outputs
  logic                           valid_q;
  logic                           sign_q;
  logic                           zero_q;
  logic [i2f_pkg::I2F_CNT_W-1:0]  lz_cnt_q;
  logic [i2f_pkg::I2F_DATA_W-1:0] mant_q;

  always_comb begin
    // Unsigned mode never produces a negative sign
    sign = ~req_i.is_unsigned & req_i.operand[i2f_pkg::I2F_DATA_W-1];
    // Two's complement negate, the most negative value maps onto 2**31 itself
    if (sign) begin
      mag = ~req_i.operand + 32'd1;
    end else begin
      mag = req_i.operand;
    end
  end

  lzc #(
    .WIDTH (i2f_pkg::I2F_DATA_W),
    .MODE  (1'b1)
  ) u_lzc (
    .in_i    (mag),
    .cnt_o   (lz_cnt),
    .empty_o (empty)
  );

  // Barrel shift left by the count
  // A zero magnitude stays zero whatever the count
  assign mant = mag << lz_cnt;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  // Payload only moves when a job arrives
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      sign_q   <= sign;
      zero_q   <= empty;
      lz_cnt_q <= lz_cnt;
      mant_q   <= mant;
    end
  end

  always_comb begin
    norm_o.valid  = valid_q;
    norm_o.sign   = sign_q;
    norm_o.zero   = zero_q;
    norm_o.lz_cnt = lz_cnt_q;
    norm_o.mant   = mant_q;
  end

endmodule

// ==== src/lzc.sv ====
// Leading or trailing zero counter
// Finds the first set bit through a binary tree of selection nodes
module lzc #(
  // Number of input bits
  parameter int unsigned WIDTH = 2,
  // 0 counts trailing zeros, 1 counts leading zeros
  parameter bit MODE = 1'b0,
  // Width of the count, follows from WIDTH and is not meant to be overridden
  parameter int unsigned CNT_WIDTH = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0]     in_i,
  output logic [CNT_WIDTH-1:0] cnt_o,
  output logic                 empty_o
);

  if (WIDTH == 1) begin : gen_single
    // A single bit is its own count and its own empty flag
    assign cnt_o[0] = ~in_i[0];
    assign empty_o  = ~in_i[0];
  end else begin : gen_tree
    localparam int unsigned Levels = $clog2(WIDTH);
    localparam int unsigned Nodes  = 2 ** Levels - 1;

    // Input in scan order, so the tree always looks for the lowest set index
    logic [WIDTH-1:0]              scan;
    // Per node, whether any bit below it is set
    logic [Nodes-1:0]              node_sel;
    // Per node, the index of the first set bit below it
    logic [Nodes-1:0][Levels-1:0]  node_idx;

    if (MODE) begin : gen_mirror
      // Leading zero mode reverses the vector so the MSB becomes index 0
      for (genvar i = 0; i < int'(WIDTH); i++) begin : gen_bit
        assign scan[i] = in_i[WIDTH-1-i];
      end
    end else begin : gen_direct
      assign scan = in_i;
    end

    // Node n of level lvl sits at 2**lvl - 1 + n, the root is node 0
    for (genvar lvl = 0; lvl < int'(Levels); lvl++) begin : gen_level
      localparam int unsigned Base = 2 ** lvl - 1;
      for (genvar k = 0; k < 2 ** lvl; k++) begin : gen_node
        if (lvl == int'(Levels) - 1) begin : gen_leaf
          // Leaves look at a pair of input bits
          if (2 * k + 1 < int'(WIDTH)) begin : gen_pair
            assign node_sel[Base+k] = scan[2*k] | scan[2*k+1];
            assign node_idx[Base+k] = scan[2*k] ? (Levels)'(2 * k) : (Levels)'(2 * k + 1);
          end else if (2 * k < int'(WIDTH)) begin : gen_lone
            // Odd width leaves one bit without a partner
            assign node_sel[Base+k] = scan[2*k];
            assign node_idx[Base+k] = (Levels)'(2 * k);
          end else begin : gen_void
            assign node_sel[Base+k] = 1'b0;
            assign node_idx[Base+k] = '0;
          end
        end else begin : gen_inner
          // Inner nodes prefer the left child, which holds the lower indices
          localparam int unsigned Left = 2 ** (lvl + 1) - 1 + 2 * k;
          assign node_sel[Base+k] = node_sel[Left] | node_sel[Left+1];
          assign node_idx[Base+k] = node_sel[Left] ? node_idx[Left] : node_idx[Left+1];
        end
      end
    end

    // With no bit set the tree falls through to the last index, WIDTH - 1
    assign cnt_o   = node_idx[0];
    assign empty_o = ~node_sel[0];
  end

endmodule

// ==== common/i2f_pkg.sv ====
// Shared definitions of the integer-to-float converter
// Holds the APB bus structs, the pipeline payloads, the float word view and the register map
package i2f_pkg;

  // Width of the integer operand and of the float result
  localparam int unsigned I2F_DATA_W = 32;
  // Width of the leading zero count
  localparam int unsigned I2F_CNT_W = 5;

  // Single precision field widths
  localparam int unsigned FP_EXP_W = 8;
  localparam int unsigned FP_MAN_W = 23;
  // Exponent of a normalised 32-bit magnitude with no leading zeros (127 + 31)
  localparam logic [FP_EXP_W-1:0] FP_EXP_BASE = 8'd158;

  // Register offsets on the APB bus
  localparam logic [I2F_DATA_W-1:0] ADDR_DATA   = 32'h0000_0000;
  localparam logic [I2F_DATA_W-1:0] ADDR_RESULT = 32'h0000_0004;
  localparam logic [I2F_DATA_W-1:0] ADDR_STATUS = 32'h0000_0008;
  localparam logic [I2F_DATA_W-1:0] ADDR_CTRL   = 32'h0000_000C;

  // Bit positions of the flags in STATUS, the count sits in the low bits
  localparam int unsigned STATUS_ZERO_BIT = 8;
  localparam int unsigned STATUS_BUSY_BIT = 9;

  // Request from the APB master
  typedef struct packed {
    logic [I2F_DATA_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [I2F_DATA_W-1:0] pwdata;
  } apb_req_t;

  // Response of the APB slave
  typedef struct packed {
    logic [I2F_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // One conversion job handed to the norm stage
  typedef struct packed {
    logic                  valid;
    logic [I2F_DATA_W-1:0] operand;
    logic                  is_unsigned;
  } conv_req_t;

  // Normalised magnitude passed from the norm stage to the round stage
  typedef struct packed {
    logic                  valid;
    logic                  sign;
    logic                  zero;
    logic [I2F_CNT_W-1:0]  lz_cnt;
    logic [I2F_DATA_W-1:0] mant;
  } norm_t;

  // Field view of an IEEE-754 single precision word
  typedef struct packed {
    logic                sign;
    logic [FP_EXP_W-1:0] exponent;
    logic [FP_MAN_W-1:0] mantissa;
  } fp32_fields_t;

  // The same word seen either as raw bits or as its fields
  typedef union packed {
    logic [I2F_DATA_W-1:0] bits;
    fp32_fields_t          fields;
  } fp32_u;

endpackage
